// File: src/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h1c00_0000

// architectural register count, r0 reads as zero
`define CORE_NREGS    32

// datapath width
`define CORE_XLEN     32

`endif

// File: src/pipeline_types.sv
`include "core_cfg.svh"

package pipeline_types;

    localparam int REG_AW = $clog2(`CORE_NREGS);

    typedef logic [`CORE_XLEN-1:0] bus32_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LU12I,
        OP_LDW,
        OP_STW,
        OP_BEQ,
        OP_BNE,
        OP_B,
        OP_ILL
    } opcode_e;

    typedef enum logic [1:0] {
        F_IDLE,  // waiting for the next pc
        F_REQ,   // request on the bus
        F_WAIT,  // waiting for the response
        F_HOLD   // packet held for decode
    } fetch_state_e;

    typedef struct packed {
        bus32_t pc;
        bus32_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        bus32_t            pc;
        bus32_t            inst;
        opcode_e           opcode;
        logic [REG_AW-1:0] rd;
        bus32_t            opa;  // rj value
        bus32_t            opb;  // rk or rd value
        bus32_t            imm;  // already extended / shifted
    } decoded_t;

    typedef struct packed {
        bus32_t            pc;
        bus32_t            inst;
        logic              we;
        logic [REG_AW-1:0] rd;
        bus32_t            wdata;
        bus32_t            next_pc;
        logic              illegal;
    } exe_result_t;

    typedef struct packed {
        bus32_t            pc;
        bus32_t            inst;
        logic              we;
        logic [REG_AW-1:0] rnum;
        bus32_t            wdata;
        logic              illegal;
    } retire_t;

    typedef struct packed {
        bus32_t addr;
    } imem_req_t;

    typedef struct packed {
        logic       we;
        bus32_t     addr;
        bus32_t     wdata;
        logic [3:0] strb;
    } dmem_req_t;

endpackage

// File: src/fetch_unit.sv
`include "core_cfg.svh"

module fetch_unit
    import pipeline_types::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       next_pc_valid_i,
    input  bus32_t     next_pc_i,
    output logic       imem_req_valid_o,
    input  logic       imem_req_ready_i,
    output imem_req_t  imem_req_o,
    input  logic       imem_rsp_valid_i,
    input  bus32_t     imem_rsp_data_i,
    output logic       fetch_valid_o,
    input  logic       fetch_ready_i,
    output fetch_pkt_t fetch_pkt_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    bus32_t       pc_q;
    logic         boot_q;
    fetch_pkt_t   pkt_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            F_IDLE: if (boot_q || next_pc_valid_i) state_d = F_REQ;
            F_REQ:  if (imem_req_ready_i) state_d = F_WAIT;
            F_WAIT: if (imem_rsp_valid_i) state_d = F_HOLD;
            F_HOLD: if (fetch_ready_i) state_d = F_IDLE;
            default: state_d = F_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= F_IDLE;
            pc_q    <= `CORE_RESET_PC;
            boot_q  <= 1'b1;  // first fetch needs no next pc
        end else begin
            state_q <= state_d;
            if (state_q == F_REQ) boot_q <= 1'b0;
            if (state_q == F_IDLE && next_pc_valid_i) pc_q <= next_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == F_WAIT && imem_rsp_valid_i) begin
            pkt_q.pc   <= pc_q;
            pkt_q.inst <= imem_rsp_data_i;
        end
    end

    assign imem_req_valid_o = (state_q == F_REQ);
    assign imem_req_o.addr  = pc_q;  // pc only moves in idle, so stable under stall
    assign fetch_valid_o    = (state_q == F_HOLD);
    assign fetch_pkt_o      = pkt_q;

endmodule

// File: src/regfile.sv
`include "core_cfg.svh"

module regfile
    import pipeline_types::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [REG_AW-1:0] ra_i,
    input  logic [REG_AW-1:0] rb_i,
    output bus32_t            rdata_a_o,
    output bus32_t            rdata_b_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  bus32_t            wdata_i
);

    bus32_t regs_q [`CORE_NREGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin  // r0 is hardwired
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (ra_i == '0) ? '0 : regs_q[ra_i];
    assign rdata_b_o = (rb_i == '0) ? '0 : regs_q[rb_i];

endmodule

// File: src/decode_unit.sv
module decode_unit
    import pipeline_types::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              fetch_valid_i,
    output logic              fetch_ready_o,
    input  fetch_pkt_t        fetch_pkt_i,
    output logic [REG_AW-1:0] rf_ra_o,
    output logic [REG_AW-1:0] rf_rb_o,
    input  bus32_t            rf_rdata_a_i,
    input  bus32_t            rf_rdata_b_i,
    output logic              dec_valid_o,
    input  logic              dec_ready_i,
    output decoded_t          dec_o
);

    bus32_t   inst;
    opcode_e  opcode;
    bus32_t   imm;
    logic     is_3r;
    logic     accept;
    logic     dec_valid_q;
    decoded_t dec_q;

    assign inst = fetch_pkt_i.inst;

    // LA32R major opcode fields
    always_comb begin
        casez (inst[31:15])
            17'h00020:             opcode = OP_ADD;
            17'h00022:             opcode = OP_SUB;
            17'h00024:             opcode = OP_SLT;
            17'h00029:             opcode = OP_AND;
            17'h0002a:             opcode = OP_OR;
            17'h0002b:             opcode = OP_XOR;
            17'b0000001010???????: opcode = OP_ADDI;
            17'b0001010??????????: opcode = OP_LU12I;
            17'b0010100010???????: opcode = OP_LDW;
            17'b0010100110???????: opcode = OP_STW;
            17'b010100???????????: opcode = OP_B;
            17'b010110???????????: opcode = OP_BEQ;
            17'b010111???????????: opcode = OP_BNE;
            default:               opcode = OP_ILL;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ADDI, OP_LDW, OP_STW: imm = {{20{inst[21]}}, inst[21:10]};  // si12
            OP_LU12I:                imm = {inst[24:5], 12'b0};           // si20 << 12
            OP_BEQ, OP_BNE:          imm = {{14{inst[25]}}, inst[25:10], 2'b00};
            OP_B:                    imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            default:                 imm = '0;
        endcase
    end

    assign is_3r   = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
    assign rf_ra_o = inst[9:5];                           // rj
    assign rf_rb_o = is_3r ? inst[14:10] : inst[4:0];     // rk, or rd for st / branch

    assign fetch_ready_o = !dec_valid_q || dec_ready_i;
    assign accept        = fetch_valid_i && fetch_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_q <= 1'b0;
        end else if (accept) begin
            dec_valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_q.pc     <= fetch_pkt_i.pc;
            dec_q.inst   <= inst;
            dec_q.opcode <= opcode;
            dec_q.rd     <= inst[4:0];
            dec_q.opa    <= rf_rdata_a_i;
            dec_q.opb    <= rf_rdata_b_i;
            dec_q.imm    <= imm;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

endmodule

// File: src/execute_unit.sv
module execute_unit
    import pipeline_types::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        dec_valid_i,
    output logic        dec_ready_o,
    input  decoded_t    dec_i,
    output logic        dmem_req_valid_o,
    input  logic        dmem_req_ready_i,
    output dmem_req_t   dmem_req_o,
    input  logic        dmem_rsp_valid_i,
    input  bus32_t      dmem_rsp_data_i,
    output logic        exe_valid_o,
    output exe_result_t exe_o
);

    logic        accept;
    logic        is_mem;
    logic        taken;
    bus32_t      alu_res;
    exe_result_t res;
    logic        mem_req_q;
    logic        mem_wait_q;
    logic        exe_valid_q;
    exe_result_t exe_q;
    dmem_req_t   dmem_req_q;

    always_comb begin
        case (dec_i.opcode)
            OP_ADD:                  alu_res = dec_i.opa + dec_i.opb;
            OP_SUB:                  alu_res = dec_i.opa - dec_i.opb;
            OP_AND:                  alu_res = dec_i.opa & dec_i.opb;
            OP_OR:                   alu_res = dec_i.opa | dec_i.opb;
            OP_XOR:                  alu_res = dec_i.opa ^ dec_i.opb;
            OP_SLT:                  alu_res = {31'b0, $signed(dec_i.opa) < $signed(dec_i.opb)};
            OP_ADDI, OP_LDW, OP_STW: alu_res = dec_i.opa + dec_i.imm;  // also the mem address
            OP_LU12I:                alu_res = dec_i.imm;
            default:                 alu_res = '0;
        endcase
    end

    assign taken = (dec_i.opcode == OP_B)
                || (dec_i.opcode == OP_BEQ && dec_i.opa == dec_i.opb)
                || (dec_i.opcode == OP_BNE && dec_i.opa != dec_i.opb);

    assign is_mem = dec_i.opcode inside {OP_LDW, OP_STW};

    always_comb begin
        res.pc      = dec_i.pc;
        res.inst    = dec_i.inst;
        res.we      = dec_i.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                           OP_ADDI, OP_LU12I, OP_LDW};
        res.rd      = dec_i.rd;
        res.wdata   = alu_res;
        res.next_pc = taken ? dec_i.pc + dec_i.imm : dec_i.pc + 32'd4;
        res.illegal = (dec_i.opcode == OP_ILL);
    end

    assign dec_ready_o = !(mem_req_q || mem_wait_q);
    assign accept      = dec_valid_i && dec_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_req_q   <= 1'b0;
            mem_wait_q  <= 1'b0;
            exe_valid_q <= 1'b0;
        end else begin
            exe_valid_q <= 1'b0;  // single cycle pulse
            if (accept) begin
                if (is_mem) mem_req_q <= 1'b1;
                else exe_valid_q <= 1'b1;
            end
            if (mem_req_q && dmem_req_ready_i) begin
                mem_req_q  <= 1'b0;
                mem_wait_q <= 1'b1;
            end
            if (mem_wait_q && dmem_rsp_valid_i) begin
                mem_wait_q  <= 1'b0;
                exe_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exe_q            <= res;
            dmem_req_q.we    <= (dec_i.opcode == OP_STW);
            dmem_req_q.addr  <= alu_res;
            dmem_req_q.wdata <= dec_i.opb;
            dmem_req_q.strb  <= (dec_i.opcode == OP_STW) ? 4'b1111 : 4'b0000;  // word stores only
        end else if (mem_wait_q && dmem_rsp_valid_i && !dmem_req_q.we) begin
            exe_q.wdata <= dmem_rsp_data_i;  // load data
        end
    end

    assign dmem_req_valid_o = mem_req_q;
    assign dmem_req_o       = dmem_req_q;
    assign exe_valid_o      = exe_valid_q;
    assign exe_o            = exe_q;

endmodule

// File: src/result_unit.sv
module result_unit
    import pipeline_types::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              exe_valid_i,
    input  exe_result_t       exe_i,
    output logic              rf_we_o,
    output logic [REG_AW-1:0] rf_waddr_o,
    output bus32_t            rf_wdata_o,
    output logic              next_pc_valid_o,
    output bus32_t            next_pc_o,
    output logic              retire_valid_o,
    output retire_t           retire_o
);

    logic    valid_q;
    retire_t retire_q;
    bus32_t  next_pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= exe_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            retire_q.pc      <= exe_i.pc;
            retire_q.inst    <= exe_i.inst;
            retire_q.we      <= exe_i.we && (exe_i.rd != '0);  // r0 writes have no effect
            retire_q.rnum    <= exe_i.rd;
            retire_q.wdata   <= exe_i.wdata;
            retire_q.illegal <= exe_i.illegal;
            next_pc_q        <= exe_i.next_pc;
        end
    end

    assign rf_we_o    = valid_q && retire_q.we;
    assign rf_waddr_o = retire_q.rnum;
    assign rf_wdata_o = retire_q.wdata;

    assign next_pc_valid_o = valid_q;
    assign next_pc_o       = next_pc_q;
    assign retire_valid_o  = valid_q;
    assign retire_o        = retire_q;

endmodule

// File: src/cpu.sv
module cpu
    import pipeline_types::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    output logic      imem_req_valid_o,
    input  logic      imem_req_ready_i,
    output imem_req_t imem_req_o,
    input  logic      imem_rsp_valid_i,
    input  bus32_t    imem_rsp_data_i,

    output logic      dmem_req_valid_o,
    input  logic      dmem_req_ready_i,
    output dmem_req_t dmem_req_o,
    input  logic      dmem_rsp_valid_i,
    input  bus32_t    dmem_rsp_data_i,

    output logic      retire_valid_o,
    output retire_t   retire_o
);

    logic              fetch_valid;
    logic              fetch_ready;
    fetch_pkt_t        fetch_pkt;
    logic              dec_valid;
    logic              dec_ready;
    decoded_t          dec;
    logic              exe_valid;
    exe_result_t       exe;
    logic              next_pc_valid;
    bus32_t            next_pc;
    logic [REG_AW-1:0] rf_ra;
    logic [REG_AW-1:0] rf_rb;
    bus32_t            rf_rdata_a;
    bus32_t            rf_rdata_b;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    bus32_t            rf_wdata;

    fetch_unit u_fetch_unit (
        .clk,
        .arst_n_i,
        .next_pc_valid_i  (next_pc_valid),
        .next_pc_i        (next_pc),
        .imem_req_valid_o,
        .imem_req_ready_i,
        .imem_req_o,
        .imem_rsp_valid_i,
        .imem_rsp_data_i,
        .fetch_valid_o    (fetch_valid),
        .fetch_ready_i    (fetch_ready),
        .fetch_pkt_o      (fetch_pkt)
    );

    decode_unit u_decode_unit (
        .clk,
        .arst_n_i,
        .fetch_valid_i (fetch_valid),
        .fetch_ready_o (fetch_ready),
        .fetch_pkt_i   (fetch_pkt),
        .rf_ra_o       (rf_ra),
        .rf_rb_o       (rf_rb),
        .rf_rdata_a_i  (rf_rdata_a),
        .rf_rdata_b_i  (rf_rdata_b),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_o         (dec)
    );

    regfile u_regfile (
        .clk,
        .arst_n_i,
        .ra_i      (rf_ra),
        .rb_i      (rf_rb),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    execute_unit u_execute_unit (
        .clk,
        .arst_n_i,
        .dec_valid_i      (dec_valid),
        .dec_ready_o      (dec_ready),
        .dec_i            (dec),
        .dmem_req_valid_o,
        .dmem_req_ready_i,
        .dmem_req_o,
        .dmem_rsp_valid_i,
        .dmem_rsp_data_i,
        .exe_valid_o      (exe_valid),
        .exe_o            (exe)
    );

    result_unit u_result_unit (
        .clk,
        .arst_n_i,
        .exe_valid_i     (exe_valid),
        .exe_i           (exe),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .next_pc_valid_o (next_pc_valid),
        .next_pc_o       (next_pc),
        .retire_valid_o,
        .retire_o
    );

endmodule

// File: dv/cpu_properties.sv
module cpu_properties
    import pipeline_types::*;
(
    input logic      clk,
    input logic      arst_n_i,
    input logic      imem_req_valid_o,
    input logic      imem_req_ready_i,
    input imem_req_t imem_req_o,
    input logic      dmem_req_valid_o,
    input logic      dmem_req_ready_i,
    input dmem_req_t dmem_req_o,
    input logic      retire_valid_o,
    input retire_t   retire_o
);

    a_imem_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        imem_req_valid_o && !imem_req_ready_i |=> imem_req_valid_o && $stable(imem_req_o))
        else $error("imem request changed while stalled");

    a_dmem_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        dmem_req_valid_o && !dmem_req_ready_i |=> dmem_req_valid_o && $stable(dmem_req_o))
        else $error("dmem request changed while stalled");

    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_valid_o |-> !(retire_o.we && retire_o.rnum == '0))
        else $error("retire record writes r0");

    // one instruction in flight, so nothing retires under a data request
    a_no_retire_on_dmem: assert property (@(posedge clk) disable iff (!arst_n_i)
        dmem_req_valid_o |-> !retire_valid_o)
        else $error("retire while a dmem request is pending");

endmodule

bind cpu cpu_properties u_cpu_properties (.*);

// File: dv/cpu_tb.sv
`include "core_cfg.svh"

module cpu_tb
    import pipeline_types::*;
;

    logic      clk;
    logic      arst_n_i;
    logic      imem_req_valid_o;
    logic      imem_req_ready_i;
    imem_req_t imem_req_o;
    logic      imem_rsp_valid_i;
    bus32_t    imem_rsp_data_i;
    logic      dmem_req_valid_o;
    logic      dmem_req_ready_i;
    dmem_req_t dmem_req_o;
    logic      dmem_rsp_valid_i;
    bus32_t    dmem_rsp_data_i;
    logic      retire_valid_o;
    retire_t   retire_o;

    bus32_t    mem [1024];    // shared by both ports, index is addr[11:2]
    bus32_t    m_mem [1024];  // reference model copy
    bus32_t    m_regs [32];
    bus32_t    m_pc;
    retire_t   ret_q [$];
    retire_t   last_run [$];
    int        checks;
    int        errors;
    int        timeouts;
    logic      i_busy, d_busy;
    int        i_lat, d_lat;
    bus32_t    i_addr;
    dmem_req_t d_req;

    cpu u_cpu (.*);

    always #5 clk = ~clk;

    always @(negedge clk) begin
        imem_rsp_valid_i = 1'b0;
        dmem_rsp_valid_i = 1'b0;
        if (!arst_n_i) begin
            imem_req_ready_i = 1'b0;
            dmem_req_ready_i = 1'b0;
            i_busy = 1'b0;
            d_busy = 1'b0;
        end else begin
            if (i_busy) begin
                if (i_lat == 0) begin
                    imem_rsp_valid_i = 1'b1;
                    imem_rsp_data_i  = mem[i_addr[11:2]];
                    i_busy = 1'b0;
                end else i_lat--;
            end
            if (d_busy) begin
                if (d_lat == 0) begin
                    dmem_rsp_valid_i = 1'b1;
                    dmem_rsp_data_i  = d_req.we ? '0 : mem[d_req.addr[11:2]];
                    d_busy = 1'b0;
                end else d_lat--;
            end
            imem_req_ready_i = ($urandom_range(0, 3) != 0);
            dmem_req_ready_i = ($urandom_range(0, 3) != 0);
            // handshake happens on the coming rising edge
            if (imem_req_valid_o && imem_req_ready_i && !i_busy) begin
                i_busy = 1'b1;
                i_lat  = $urandom_range(0, 3);
                i_addr = imem_req_o.addr;
            end
            if (dmem_req_valid_o && dmem_req_ready_i && !d_busy) begin
                d_busy = 1'b1;
                d_lat  = $urandom_range(0, 3);
                d_req  = dmem_req_o;
                for (int b = 0; b < 4; b++) begin
                    if (d_req.we && d_req.strb[b])
                        mem[d_req.addr[11:2]][8*b +: 8] = d_req.wdata[8*b +: 8];
                end
            end
        end
        if (arst_n_i && retire_valid_o) ret_q.push_back(retire_o);
    end

    function automatic bus32_t enc_3r(logic [16:0] op, logic [4:0] rd, rj, rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic bus32_t enc_i12(logic [9:0] op, logic [4:0] rd, rj, logic [11:0] si);
        return {op, si, rj, rd};
    endfunction

    function automatic bus32_t enc_br(logic [5:0] op, logic [4:0] rj, rd, int bytes);
        logic [25:0] w;
        w = 26'(bytes >>> 2);
        if (op == 6'b010100) return {op, w[15:0], w[25:16]};
        return {op, w[15:0], rj, rd};
    endfunction

    // steps the ISA one instruction on the model state
    function automatic retire_t model_step();
        retire_t r;
        bus32_t  inst, a, b, si12, res, npc, addr;
        logic    we, ill;
        inst = m_mem[m_pc[11:2]];
        a    = m_regs[inst[9:5]];
        b    = m_regs[inst[4:0]];
        si12 = {{20{inst[21]}}, inst[21:10]};
        addr = a + si12;
        npc  = m_pc + 32'd4;
        we   = 1'b1;
        ill  = 1'b0;
        res  = '0;
        case (inst[31:15])
            17'h00020: res = a + m_regs[inst[14:10]];
            17'h00022: res = a - m_regs[inst[14:10]];
            17'h00024: res = {31'b0, $signed(a) < $signed(m_regs[inst[14:10]])};
            17'h00029: res = a & m_regs[inst[14:10]];
            17'h0002a: res = a | m_regs[inst[14:10]];
            17'h0002b: res = a ^ m_regs[inst[14:10]];
            default: begin
                we = 1'b0;
                if (inst[31:22] == 10'h00a) begin
                    we  = 1'b1;
                    res = addr;
                end else if (inst[31:25] == 7'h0a) begin
                    we  = 1'b1;
                    res = {inst[24:5], 12'b0};
                end else if (inst[31:22] == 10'h0a2) begin
                    we  = 1'b1;
                    res = m_mem[addr[11:2]];
                end else if (inst[31:22] == 10'h0a6) begin
                    m_mem[addr[11:2]] = b;
                end else if (inst[31:26] == 6'b010100) begin
                    npc = m_pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
                end else if (inst[31:26] == 6'b010110 || inst[31:26] == 6'b010111) begin
                    if ((a == b) == (inst[26] == 1'b0))
                        npc = m_pc + {{14{inst[25]}}, inst[25:10], 2'b00};
                end else ill = 1'b1;
            end
        endcase
        r = '{pc: m_pc, inst: inst, we: we && inst[4:0] != 5'd0, rnum: inst[4:0],
              wdata: res, illegal: ill};
        if (r.we) m_regs[inst[4:0]] = res;
        m_pc = npc;
        return r;
    endfunction

    task automatic check_word(bus32_t got, bus32_t exp, string what);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire(retire_t got, retire_t exp);
        checks++;
        if (got.pc !== exp.pc || got.inst !== exp.inst || got.we !== exp.we
            || got.rnum !== exp.rnum || got.illegal !== exp.illegal
            || (exp.we && got.wdata !== exp.wdata)) begin
            $display("FAILED at %0t: retire pc %h inst %h we %b r%0d data %h ill %b", $time,
                     got.pc, got.inst, got.we, got.rnum, got.wdata, got.illegal);
            $display("    expected pc %h inst %h we %b r%0d data %h ill %b",
                     exp.pc, exp.inst, exp.we, exp.rnum, exp.wdata, exp.illegal);
            errors++;
        end
    endtask

    // waits for n retires and compares each with the model
    task automatic run_retires(int n);
        retire_t got;
        logic    ok;
        last_run.delete();
        for (int i = 0; i < n; i++) begin
            ok = 1'b0;
            for (int t = 0; t < 400 && !ok; t++) begin
                if (ret_q.size() != 0) begin
                    got = ret_q.pop_front();
                    ok  = 1'b1;
                end else @(negedge clk);
            end
            if (!ok) begin
                $display("timeout: core stalled, no instruction retired in 400 cycles");
                timeouts++;
                return;
            end
            last_run.push_back(got);
            check_retire(got, model_step());
        end
    endtask

    task automatic test_alu();
        run_retires(12);
        if (timeouts != 0) return;
        check_word(last_run[2].wdata, 32'hffff_fffe, "SUB.W wraparound");
        check_word(last_run[4].wdata, 32'd1, "SLT -3 < 5");
        check_word(last_run[5].wdata, 32'd0, "SLT 5 < -3");
        check_word(last_run[7].wdata, 32'h1234_5678, "LU12I.W then ADDI.W");
    endtask

    task automatic test_r0();
        run_retires(2);
        if (timeouts != 0) return;
        check_word(bus32_t'(last_run[0].we), 32'd0, "write enable for r0");
        check_word(last_run[1].wdata, 32'd0, "read of r0");
    endtask

    task automatic test_mem();
        run_retires(7);
        if (timeouts != 0) return;
        check_word(last_run[4].wdata, 32'hffff_fffe, "load of stored r3");
        check_word(last_run[5].wdata, 32'h1234_5678, "load of stored r7");
    endtask

    task automatic test_branch();
        run_retires(14);  // skipped ADDI r17 would break the pc order
    endtask

    task automatic test_illegal();
        run_retires(2);
        if (timeouts != 0) return;
        check_word(bus32_t'(last_run[0].illegal), 32'd1, "illegal flag");
        check_word(last_run[1].pc, `CORE_RESET_PC + 32'd132, "pc after illegal");  // word 33
    endtask

    task automatic load_program();
        bus32_t p [$];
        p = '{enc_i12(10'h00a, 1, 0, 12'd5), enc_i12(10'h00a, 2, 0, 12'd7),
              enc_3r(17'h00022, 3, 1, 2), enc_i12(10'h00a, 4, 0, -12'sd3),
              enc_3r(17'h00024, 5, 4, 1), enc_3r(17'h00024, 6, 1, 4),
              {7'h0a, 20'h12345, 5'd7}, enc_i12(10'h00a, 7, 7, 12'h678),
              enc_3r(17'h00029, 8, 7, 3), enc_3r(17'h0002a, 9, 1, 2),
              enc_3r(17'h0002b, 10, 7, 3), enc_3r(17'h00020, 11, 7, 1),
              enc_i12(10'h00a, 0, 0, 12'd9), enc_3r(17'h00020, 12, 0, 0),
              enc_i12(10'h00a, 13, 0, 12'h400), enc_i12(10'h0a6, 7, 13, 12'd0),
              enc_i12(10'h0a6, 3, 13, 12'd4), enc_i12(10'h0a6, 1, 13, 12'd8),
              enc_i12(10'h0a2, 14, 13, 12'd4), enc_i12(10'h0a2, 15, 13, 12'd0),
              enc_i12(10'h0a2, 16, 13, 12'd12),
              enc_br(6'b010110, 1, 2, 8), enc_br(6'b010111, 1, 2, 8),
              enc_i12(10'h00a, 17, 0, 12'd1), enc_br(6'b010100, 0, 0, 8),
              enc_i12(10'h00a, 17, 0, 12'd2), enc_i12(10'h00a, 18, 0, 12'd0),
              enc_i12(10'h00a, 18, 18, 12'd1), enc_i12(10'h00a, 19, 0, 12'd3),
              enc_br(6'b010111, 18, 19, -8), enc_br(6'b010110, 18, 19, 8),
              enc_i12(10'h00a, 17, 0, 12'd3),
              32'hffff_ffff, enc_i12(10'h00a, 20, 0, 12'h055),
              enc_br(6'b010100, 0, 0, 0)};
        for (int i = 0; i < 1024; i++) mem[i] = {i[15:0] ^ 16'h5a5a, ~i[15:0]};
        for (int i = 0; i < p.size(); i++) mem[i] = p[i];
        m_mem = mem;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        m_pc = `CORE_RESET_PC;
    endtask

    initial begin
        clk = 1'b0;
        arst_n_i = 1'b0;
        imem_req_ready_i = 1'b0;
        imem_rsp_valid_i = 1'b0;
        imem_rsp_data_i = '0;
        dmem_req_ready_i = 1'b0;
        dmem_rsp_valid_i = 1'b0;
        dmem_rsp_data_i = '0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        void'($urandom(66328));
        load_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        test_alu();
        if (timeouts == 0) test_r0();
        if (timeouts == 0) test_mem();
        if (timeouts == 0) test_branch();
        if (timeouts == 0) test_illegal();
        for (int i = 256; i < 260 && timeouts == 0; i++) check_word(mem[i], m_mem[i], "memory word");
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+src
src/pipeline_types.sv
src/fetch_unit.sv
src/regfile.sv
src/decode_unit.sv
src/execute_unit.sv
src/result_unit.sv
src/cpu.sv
dv/cpu_properties.sv
dv/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module cpu_tb -f sim.f -o cpu_sim > sim.log 2>&1 \
    && ./obj_dir/cpu_sim >> sim.log 2>&1 \
    || echo "Test failures found" >> sim.log

cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
